//--- common/nabp_pkg.sv
`default_nettype none

package nabp_pkg;

    // image and sinogram geometry
    localparam int k_image_size = 8;
    localparam int k_no_of_angles = 4;
    localparam int k_no_of_partitions = 4;
    localparam int k_rows_per_pe = 2;

    // derived pixel counts
    localparam int k_pe_pixels = k_rows_per_pe * k_image_size;
    localparam int k_image_pixels = k_image_size * k_image_size;

    // datapath widths
    localparam int k_sample_width = 8;
    localparam int k_filtered_width = 11;
    localparam int k_pixel_width = 16;

    typedef logic [k_sample_width-1:0] sample_t;
    typedef logic signed [k_filtered_width-1:0] filtered_t;
    typedef logic signed [k_pixel_width-1:0] pixel_t;
    typedef logic [1:0] angle_t;
    typedef logic [2:0] s_index_t;
    typedef logic [5:0] pixel_index_t;

    // raw sample with its position in the sinogram
    typedef struct packed {
        sample_t  sample;
        angle_t   angle;
        s_index_t s_index;
        logic     line_end;
    } tagged_sample_t;

    // one whole filtered projection line
    typedef struct packed {
        angle_t                         angle;
        filtered_t [k_image_size-1:0]   samples;
    } filtered_line_t;

    // output pixel, row-major index
    typedef struct packed {
        pixel_index_t pixel_index;
        pixel_t       value;
        logic         frame_last;
    } image_beat_t;

endpackage

`default_nettype wire

//--- sinogram/sinogram_addresser.sv
`timescale 1ns/1ps
`default_nettype none

module sinogram_addresser (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  nabp_pkg::sample_t        in_sample,
    output logic                     in_ready,
    output logic                     out_valid,
    output nabp_pkg::tagged_sample_t out_tag,
    input  logic                     out_ready
);

    // position of the next sample in the frame
    nabp_pkg::s_index_t s_index;
    nabp_pkg::angle_t   angle;
    logic               accept;
    logic               last_in_line;

    // pure pass-through handshake, no register stage
    assign out_valid = in_valid;
    assign in_ready = out_ready;
    assign accept = in_valid && out_ready;
    assign last_in_line = s_index == nabp_pkg::s_index_t'(nabp_pkg::k_image_size - 1);

    assign out_tag.sample = in_sample;
    assign out_tag.angle = angle;
    assign out_tag.s_index = s_index;
    assign out_tag.line_end = last_in_line;

    always_ff @(posedge clk) begin
        if (reset) begin
            s_index <= '0;
            angle <= '0;
        end else if (accept) begin
            s_index <= s_index + nabp_pkg::s_index_t'(1);
            // angle wraps after 3, next frame follows directly
            if (last_in_line) begin
                angle <= angle + nabp_pkg::angle_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- sinogram/ramp_filter.sv
`timescale 1ns/1ps
`default_nettype none

module ramp_filter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  nabp_pkg::tagged_sample_t in_tag,
    output logic                     in_ready,
    output logic                     wr_valid,
    output nabp_pkg::s_index_t       wr_index,
    output nabp_pkg::angle_t         wr_angle,
    output nabp_pkg::filtered_t      wr_value,
    output logic                     wr_line_end,
    input  logic                     wr_ready
);

    // history of the current line, zero at line start
    nabp_pkg::filtered_t prev1;
    nabp_pkg::filtered_t prev2;
    nabp_pkg::filtered_t in_ext;
    nabp_pkg::filtered_t right;
    nabp_pkg::filtered_t filt_value;
    logic                flush;
    logic                advance;
    logic                accept;

    // output register free or emptying this cycle
    assign advance = !wr_valid || wr_ready;
    // flush cycle takes no new sample
    assign in_ready = !flush && advance;
    assign accept = in_valid && in_ready;

    assign in_ext = nabp_pkg::filtered_t'({3'b000, in_tag.sample});
    // zero padding on the right during the flush
    assign right = flush ? '0 : in_ext;
    // 2 * centre minus both neighbours
    assign filt_value = (prev1 <<< 1) - prev2 - right;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_valid <= 1'b0;
            wr_index <= '0;
            wr_angle <= '0;
            wr_value <= '0;
            wr_line_end <= 1'b0;
            prev1 <= '0;
            prev2 <= '0;
            flush <= 1'b0;
        end else if (flush && advance) begin
            // last sample of the line, history cleared
            wr_valid <= 1'b1;
            wr_index <= nabp_pkg::s_index_t'(nabp_pkg::k_image_size - 1);
            wr_value <= filt_value;
            wr_line_end <= 1'b1;
            prev1 <= '0;
            prev2 <= '0;
            flush <= 1'b0;
        end else if (accept) begin
            // sample s finishes filtered sample s-1
            wr_valid <= in_tag.s_index != '0;
            wr_index <= in_tag.s_index - nabp_pkg::s_index_t'(1);
            wr_angle <= in_tag.angle;
            wr_value <= filt_value;
            wr_line_end <= 1'b0;
            prev2 <= prev1;
            prev1 <= in_ext;
            flush <= in_tag.line_end;
        end else if (wr_ready) begin
            wr_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/line_swap_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_swap_buffer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_valid,
    input  nabp_pkg::s_index_t       wr_index,
    input  nabp_pkg::angle_t         wr_angle,
    input  nabp_pkg::filtered_t      wr_value,
    input  logic                     wr_line_end,
    output logic                     wr_ready,
    output logic                     line_valid,
    output nabp_pkg::filtered_line_t line,
    input  logic                     line_release
);

    // two line banks, ping-pong
    nabp_pkg::filtered_line_t banks [2];
    logic [1:0]               full;
    logic                     wr_ptr;
    logic                     rd_ptr;
    logic                     wr_fire;
    logic                     rd_fire;

    // stall the filter only when both banks hold lines
    assign wr_ready = !(full[0] && full[1]);
    assign wr_fire = wr_valid && wr_ready;

    // oldest full bank goes to the processing elements
    assign line_valid = full[rd_ptr];
    assign line = banks[rd_ptr];
    assign rd_fire = line_release && line_valid;

    // bank contents, one filtered sample per write
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            banks[wr_ptr].samples[wr_index] <= wr_value;
            banks[wr_ptr].angle <= wr_angle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= '0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            // line end seals the bank and hands the writer the other one
            if (wr_fire && wr_line_end) begin
                full[wr_ptr] <= 1'b1;
                wr_ptr <= !wr_ptr;
            end
            // release frees the bank in read order
            if (rd_fire) begin
                full[rd_ptr] <= 1'b0;
                rd_ptr <= !rd_ptr;
            end
        end
    end

endmodule

`default_nettype wire

//--- processing/processing_element.sv
`timescale 1ns/1ps
`default_nettype none

module processing_element #(
    parameter int pe_id = 0
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     pe_start,
    input  nabp_pkg::filtered_line_t line,
    output logic                     pe_busy,
    input  logic [3:0]               rd_index,
    input  logic                     rd_clear,
    output nabp_pkg::pixel_t         rd_pixel
);

    localparam int k_w = nabp_pkg::k_pixel_width;

    // one accumulator per owned pixel, row-major within the element
    nabp_pkg::pixel_t               acc [nabp_pkg::k_pe_pixels];
    logic [3:0]                     scan_index;
    nabp_pkg::s_index_t             x;
    nabp_pkg::s_index_t             y;
    nabp_pkg::s_index_t             s;
    nabp_pkg::filtered_t            tap;
    logic signed [k_w:0]            sum;
    nabp_pkg::pixel_t               sat_sum;

    // pixel coordinates of the scan position
    assign x = scan_index[2:0];
    assign y = nabp_pkg::s_index_t'(pe_id * nabp_pkg::k_rows_per_pe)
             + nabp_pkg::s_index_t'(scan_index[3]);

    // angle rule, pixel to detector index
    always_comb begin
        case (line.angle)
            2'd0:    s = x;
            2'd1:    s = y;
            2'd2:    s = nabp_pkg::s_index_t'(nabp_pkg::k_image_size - 1) - x;
            default: s = nabp_pkg::s_index_t'(nabp_pkg::k_image_size - 1) - y;
        endcase
    end

    assign tap = line.samples[s];

    // one extra bit catches overflow
    assign sum = acc[scan_index] + tap;

    always_comb begin
        if (sum[k_w] != sum[k_w-1]) begin
            // clamp to the pixel_t limits
            sat_sum = sum[k_w] ? {1'b1, {(k_w-1){1'b0}}} : {1'b0, {(k_w-1){1'b1}}};
        end else begin
            sat_sum = sum[k_w-1:0];
        end
    end

    // drain read port, combinational
    assign rd_pixel = acc[rd_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            pe_busy <= 1'b0;
            scan_index <= '0;
            for (int i = 0; i < nabp_pkg::k_pe_pixels; i++) begin
                acc[i] <= '0;
            end
        end else begin
            if (pe_start && !pe_busy) begin
                pe_busy <= 1'b1;
                scan_index <= '0;
            end else if (pe_busy) begin
                // one pixel per cycle, 16 cycles per line
                acc[scan_index] <= sat_sum;
                scan_index <= scan_index + 4'd1;
                if (scan_index == 4'(nabp_pkg::k_pe_pixels - 1)) begin
                    pe_busy <= 1'b0;
                end
            end else if (rd_clear) begin
                // zero on read-out, ready for the next frame
                acc[rd_index] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- processing/image_drain.sv
`timescale 1ns/1ps
`default_nettype none

module image_drain (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                drain_start,
    output logic                                                drain_done,
    output logic [3:0]                                          rd_index,
    output logic [nabp_pkg::k_no_of_partitions-1:0]             rd_clear,
    input  nabp_pkg::pixel_t [nabp_pkg::k_no_of_partitions-1:0] rd_pixel,
    output logic                                                out_valid,
    output nabp_pkg::image_beat_t                               out_beat,
    input  logic                                                out_ready
);

    logic                                          active;
    nabp_pkg::pixel_index_t                        pixel_index;
    logic [$clog2(nabp_pkg::k_no_of_partitions)-1:0] owner;
    logic                                          last_pixel;
    logic                                          load;

    // owning element and its local entry
    assign owner = $bits(owner)'(pixel_index / nabp_pkg::k_pe_pixels);
    assign rd_index = 4'(pixel_index % nabp_pkg::k_pe_pixels);
    assign last_pixel = pixel_index == nabp_pkg::pixel_index_t'(nabp_pkg::k_image_pixels - 1);

    // next pixel when the output slot is free or emptying
    assign load = active && (!out_valid || out_ready);

    // clear only the entry being read out
    always_comb begin
        rd_clear = '0;
        if (load) begin
            rd_clear[owner] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            out_valid <= 1'b0;
            drain_done <= 1'b0;
            pixel_index <= '0;
        end else begin
            // pulse once the frame's last beat moves
            drain_done <= out_valid && out_ready && out_beat.frame_last;
            if (drain_start) begin
                active <= 1'b1;
                pixel_index <= '0;
            end
            if (load) begin
                out_valid <= 1'b1;
                pixel_index <= pixel_index + nabp_pkg::pixel_index_t'(1);
                if (last_pixel) begin
                    active <= 1'b0;
                end
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // output beat payload
    always_ff @(posedge clk) begin
        if (load) begin
            out_beat.pixel_index <= pixel_index;
            out_beat.value <= rd_pixel[owner];
            out_beat.frame_last <= last_pixel;
        end
    end

endmodule

`default_nettype wire

//--- source/nabp_top.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sg_in_valid,
    input  nabp_pkg::sample_t     sg_in_sample,
    output logic                  sg_in_ready,
    output logic                  img_out_valid,
    output nabp_pkg::image_beat_t img_out_beat,
    input  logic                  img_out_ready
);

    localparam int k_parts = nabp_pkg::k_no_of_partitions;

    // addresser to filter
    nabp_pkg::tagged_sample_t tag;
    logic                     tag_valid;
    logic                     tag_ready;

    // filter to swap buffer
    logic                     wr_valid;
    nabp_pkg::s_index_t       wr_index;
    nabp_pkg::angle_t         wr_angle;
    nabp_pkg::filtered_t      wr_value;
    logic                     wr_line_end;
    logic                     wr_ready;

    // swap buffer to elements
    logic                     line_valid;
    nabp_pkg::filtered_line_t line;
    logic                     line_release;

    // sequencer
    logic [k_parts-1:0]       pe_busy;
    logic                     pe_busy_any;
    logic                     busy_q;
    logic                     pe_start;
    logic [$clog2(nabp_pkg::k_no_of_angles)-1:0] line_count;
    logic                     drain_start;
    logic                     drain_active;
    logic                     drain_done;

    // drain read port
    logic [3:0]                              rd_index;
    logic [k_parts-1:0]                      rd_clear;
    nabp_pkg::pixel_t [k_parts-1:0]          rd_pixel;

    sinogram_addresser i_sinogram_addresser (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (sg_in_valid),
        .in_sample (sg_in_sample),
        .in_ready  (sg_in_ready),
        .out_valid (tag_valid),
        .out_tag   (tag),
        .out_ready (tag_ready)
    );

    ramp_filter i_ramp_filter (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (tag_valid),
        .in_tag      (tag),
        .in_ready    (tag_ready),
        .wr_valid    (wr_valid),
        .wr_index    (wr_index),
        .wr_angle    (wr_angle),
        .wr_value    (wr_value),
        .wr_line_end (wr_line_end),
        .wr_ready    (wr_ready)
    );

    line_swap_buffer i_line_swap_buffer (
        .clk          (clk),
        .reset        (reset),
        .wr_valid     (wr_valid),
        .wr_index     (wr_index),
        .wr_angle     (wr_angle),
        .wr_value     (wr_value),
        .wr_line_end  (wr_line_end),
        .wr_ready     (wr_ready),
        .line_valid   (line_valid),
        .line         (line),
        .line_release (line_release)
    );

    // one element per row partition
    for (genvar i = 0; i < k_parts; i++) begin : g_pe
        processing_element #(
            .pe_id (i)
        ) i_processing_element (
            .clk      (clk),
            .reset    (reset),
            .pe_start (pe_start),
            .line     (line),
            .pe_busy  (pe_busy[i]),
            .rd_index (rd_index),
            .rd_clear (rd_clear[i]),
            .rd_pixel (rd_pixel[i])
        );
    end

    image_drain i_image_drain (
        .clk         (clk),
        .reset       (reset),
        .drain_start (drain_start),
        .drain_done  (drain_done),
        .rd_index    (rd_index),
        .rd_clear    (rd_clear),
        .rd_pixel    (rd_pixel),
        .out_valid   (img_out_valid),
        .out_beat    (img_out_beat),
        .out_ready   (img_out_ready)
    );

    assign pe_busy_any = |pe_busy;

    // falling edge of busy frees the line
    assign line_release = busy_q && !pe_busy_any;

    // new scan only when idle, past the release cycle, and not draining
    assign pe_start = line_valid && !pe_busy_any && !busy_q && !drain_active;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            line_count <= '0;
            drain_start <= 1'b0;
            drain_active <= 1'b0;
        end else begin
            busy_q <= pe_busy_any;
            drain_start <= 1'b0;
            if (line_release) begin
                // fourth angle done, image complete
                if (line_count == $bits(line_count)'(nabp_pkg::k_no_of_angles - 1)) begin
                    line_count <= '0;
                    drain_start <= 1'b1;
                    drain_active <= 1'b1;
                end else begin
                    line_count <= line_count + 1'b1;
                end
            end
            if (drain_done) begin
                drain_active <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/nabp_assert.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_assert (
    input logic                  clk,
    input logic                  reset,
    input logic                  sg_in_valid,
    input nabp_pkg::sample_t     sg_in_sample,
    input logic                  sg_in_ready,
    input logic                  img_out_valid,
    input nabp_pkg::image_beat_t img_out_beat,
    input logic                  img_out_ready,
    input logic                  pe_start,
    input logic                  line_valid,
    input logic                  wr_valid,
    input logic                  wr_ready,
    input logic                  wr_line_end
);

    // input stream holds its sample while stalled
    sg_in_hold: assert property (@(posedge clk) disable iff (reset)
        sg_in_valid && !sg_in_ready |=> sg_in_valid && $stable(sg_in_sample))
        else $error("sg_in sample changed or dropped while stalled");

    // output stream holds its beat while stalled
    img_out_hold: assert property (@(posedge clk) disable iff (reset)
        img_out_valid && !img_out_ready |=> img_out_valid && $stable(img_out_beat))
        else $error("img_out beat changed or dropped while stalled");

    // no scan while image beats are still going out
    no_start_in_drain: assert property (@(posedge clk) disable iff (reset)
        pe_start |-> !img_out_valid)
        else $error("pe_start issued during a drain");

    // a bank only becomes visible after a line end was written
    line_after_fill: assert property (@(posedge clk) disable iff (reset)
        $rose(line_valid) |-> $past(wr_valid && wr_ready && wr_line_end))
        else $error("line_valid rose with both banks free");

endmodule

bind nabp_top nabp_assert i_nabp_assert (
    .clk           (clk),
    .reset         (reset),
    .sg_in_valid   (sg_in_valid),
    .sg_in_sample  (sg_in_sample),
    .sg_in_ready   (sg_in_ready),
    .img_out_valid (img_out_valid),
    .img_out_beat  (img_out_beat),
    .img_out_ready (img_out_ready),
    .pe_start      (pe_start),
    .line_valid    (line_valid),
    .wr_valid      (wr_valid),
    .wr_ready      (wr_ready),
    .wr_line_end   (wr_line_end)
);

`default_nettype wire

//--- tests/tb_nabp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nabp;

    localparam int k_wait_limit = 5000;
    localparam int k_line_len = 8;
    localparam int k_frame_samples = 32;
    localparam int k_frame_pixels = 64;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  sg_in_valid;
    nabp_pkg::sample_t     sg_in_sample;
    logic                  sg_in_ready;
    logic                  img_out_valid;
    nabp_pkg::image_beat_t img_out_beat;
    logic                  img_out_ready;

    logic [31:0] lcg_state = 32'hbddd5fd2;
    int          stim_q[$];
    int          exp_q[$];
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    nabp_top i_nabp_top (
        .clk           (clk),
        .reset         (reset),
        .sg_in_valid   (sg_in_valid),
        .sg_in_sample  (sg_in_sample),
        .sg_in_ready   (sg_in_ready),
        .img_out_valid (img_out_valid),
        .img_out_beat  (img_out_beat),
        .img_out_ready (img_out_ready)
    );

    // 4 ns period
    always #2 clk = !clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits, the low ones cycle too fast
    function automatic int unsigned rand_pct();
        return (lcg_next() >> 16) % 100;
    endfunction

    function automatic int clamp_pixel(input int value);
        if (value > 32767) begin
            return 32767;
        end
        if (value < -32768) begin
            return -32768;
        end
        return value;
    endfunction

    // ramp filter and backprojection of one frame from stim_q
    function automatic void model_frame(input int base);
        int filt[4][8];
        int left;
        int right;
        int idx;
        int acc;
        for (int a = 0; a < 4; a++) begin
            for (int s = 0; s < k_line_len; s++) begin
                // zero padding at both line ends
                left = (s > 0) ? stim_q[base + a * k_line_len + s - 1] : 0;
                right = (s < k_line_len - 1) ? stim_q[base + a * k_line_len + s + 1] : 0;
                filt[a][s] = 2 * stim_q[base + a * k_line_len + s] - left - right;
            end
        end
        for (int y = 0; y < k_line_len; y++) begin
            for (int x = 0; x < k_line_len; x++) begin
                acc = 0;
                for (int a = 0; a < 4; a++) begin
                    case (a)
                        0:       idx = x;
                        1:       idx = y;
                        2:       idx = 7 - x;
                        default: idx = 7 - y;
                    endcase
                    // accumulator saturates on every add
                    acc = clamp_pixel(acc + filt[a][idx]);
                end
                exp_q.push_back(acc);
            end
        end
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("Error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic end_run();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        error_count++;
        end_run();
    endtask

    // entered on a rising edge, leaves on one
    task automatic send_samples(input int count, input int gap_pct);
        int waited;
        for (int i = 0; i < count; i++) begin
            while (rand_pct() < gap_pct) begin
                sg_in_valid <= 1'b0;
                @(posedge clk);
            end
            sg_in_valid <= 1'b1;
            sg_in_sample <= nabp_pkg::sample_t'(stim_q[i]);
            waited = 0;
            @(negedge clk);
            while (!sg_in_ready) begin
                waited++;
                if (waited > k_wait_limit) begin
                    report_timeout("sg_in_ready");
                end
                @(negedge clk);
            end
            @(posedge clk);
        end
        sg_in_valid <= 1'b0;
    endtask

    task automatic receive_images(input int n_frames, input int ready_pct);
        int waited;
        int exp_value;
        int got;
        int pos;
        for (int p = 0; p < n_frames * k_frame_pixels; p++) begin
            pos = p % k_frame_pixels;
            exp_value = exp_q.pop_front();
            waited = 0;
            forever begin
                img_out_ready <= (rand_pct() < ready_pct);
                @(negedge clk);
                if (img_out_valid && img_out_ready) begin
                    break;
                end
                waited++;
                if (waited > k_wait_limit) begin
                    report_timeout("an image beat");
                end
                @(posedge clk);
            end
            // beat moves on the coming edge
            got = img_out_beat.pixel_index;
            if (got != pos) begin
                report_mismatch("img_out_beat.pixel_index", pos, got);
            end
            got = img_out_beat.value;
            if (got != exp_value) begin
                report_mismatch("img_out_beat.value", exp_value, got);
            end
            got = img_out_beat.frame_last;
            if (got != (pos == k_frame_pixels - 1)) begin
                report_mismatch("img_out_beat.frame_last", pos == k_frame_pixels - 1, got);
            end
            @(posedge clk);
        end
        img_out_ready <= 1'b1;
    endtask

    // pattern 0 constant, 1 random, 2 alternating full scale
    task automatic run_test(input int id, input string name, input int n_frames,
                            input int pattern, input int gap_pct, input int ready_pct);
        int errors_before;
        errors_before = error_count;
        stim_q.delete();
        exp_q.delete();
        for (int i = 0; i < n_frames * k_frame_samples; i++) begin
            case (pattern)
                0:       stim_q.push_back(100);
                1:       stim_q.push_back(int'((lcg_next() >> 24) & 32'hff));
                default: stim_q.push_back((i % 2 == 0) ? 255 : 0);
            endcase
        end
        for (int f = 0; f < n_frames; f++) begin
            model_frame(f * k_frame_samples);
        end
        fork
            send_samples(n_frames * k_frame_samples, gap_pct);
            receive_images(n_frames, ready_pct);
        join
        repeat (4) @(posedge clk);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", id, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d mismatches", id, name, error_count - errors_before);
        end
    endtask

    initial begin
        reset = 1'b1;
        sg_in_valid = 1'b0;
        sg_in_sample = '0;
        img_out_ready = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // reset defaults
        @(negedge clk);
        tests_run++;
        if (sg_in_ready !== 1'b1 || img_out_valid !== 1'b0) begin
            tests_failed++;
            error_count++;
            $display("Error at %0t: sg_in_ready %b img_out_valid %b after reset", $time,
                     sg_in_ready, img_out_valid);
            $display("test 1 reset defaults: wrong idle outputs");
        end else begin
            $display("test 1 reset defaults: ok");
        end
        @(posedge clk);

        run_test(2, "constant frame", 1, 0, 0, 100);
        run_test(3, "random frame full rate", 1, 1, 0, 100);
        run_test(4, "back-pressure", 1, 1, 30, 60);
        run_test(5, "three frames back to back", 3, 1, 0, 100);
        run_test(6, "saturation pattern", 2, 2, 20, 70);
        end_run();
    end

endmodule

`default_nettype wire

//--- tb.f
common/nabp_pkg.sv
sinogram/sinogram_addresser.sv
sinogram/ramp_filter.sv
source/line_swap_buffer.sv
processing/processing_element.sv
processing/image_drain.sv
source/nabp_top.sv
tests/nabp_assert.sv
tests/tb_nabp.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the nabp testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_nabp \
    -f tb.f \
    -o tb_nabp

# a failing run still leaves its log for the search below
./obj_dir/tb_nabp > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
